/* hdl/clkrst_macros.svh */
`ifndef CLKRST_MACROS_SVH
`define CLKRST_MACROS_SVH

// Channel count and bus widths
`define CLKRST_NUM_CLOCKS        4
`define CLKRST_DIV_WIDTH         8
`define CLKRST_ADDR_WIDTH        2
`define CLKRST_DATA_WIDTH        32

// Register word addresses
`define CLKRST_ADDR_DIVISION     0
`define CLKRST_ADDR_VALID        1
`define CLKRST_ADDR_RESET        2

// Divisor after reset
`define CLKRST_DEFAULT_DIV       1

// Divided-clock edges before a domain reset releases
`define CLKRST_RESET_DELAY_WIDTH 4
`define CLKRST_RESET_DELAY       3

`endif

/* hdl/clkrst_pkg.sv */
`include "clkrst_macros.svh"

`default_nettype none

package clkrst_pkg;

  // One write data word, seen as divisor bytes or as a per-clock pulse mask
  typedef union packed {
    logic [`CLKRST_NUM_CLOCKS-1:0][`CLKRST_DIV_WIDTH-1:0] div_bytes;
    logic [`CLKRST_DATA_WIDTH-1:0]                        pulse_bits;
  } reg_data_u;

  // Write strobe with address and data
  typedef struct packed {
    logic                          en;
    logic [`CLKRST_ADDR_WIDTH-1:0] addr;
    reg_data_u                     data;
  } reg_write_t;

  // Settings handed to one output clock channel
  typedef struct packed {
    logic [`CLKRST_DIV_WIDTH-1:0] divisor;
    logic                         divisor_valid;
    logic                         local_rst;
  } chan_cfg_t;

endpackage

`default_nettype wire

/* hdl/clkrst_reg_file.sv */
`include "clkrst_macros.svh"

`default_nettype none
`timescale 1ns/1ps

module clkrst_reg_file
  import clkrst_pkg::*;
(
  input  logic                                  mst_clk_i,
  input  logic                                  control_rst_n_d2_mst_clk,
  input  reg_write_t                            reg_wr_i,
  output chan_cfg_t [`CLKRST_NUM_CLOCKS-1:0]    chan_cfg_o
);

  logic                                                 wr_division;
  logic                                                 wr_valid;
  logic                                                 wr_reset;
  logic [`CLKRST_NUM_CLOCKS-1:0][`CLKRST_DIV_WIDTH-1:0] div_q;
  logic [`CLKRST_NUM_CLOCKS-1:0]                        valid_q;
  logic [`CLKRST_NUM_CLOCKS-1:0]                        rst_q;

  ////////////////////
  // Write decode
  ////////////////////

  // Unused addresses select nothing
  always_comb begin
    wr_division = 1'b0;
    wr_valid    = 1'b0;
    wr_reset    = 1'b0;
    if (reg_wr_i.en) begin
      case (reg_wr_i.addr)
        `CLKRST_ADDR_WIDTH'(`CLKRST_ADDR_DIVISION): wr_division = 1'b1;
        `CLKRST_ADDR_WIDTH'(`CLKRST_ADDR_VALID):    wr_valid    = 1'b1;
        `CLKRST_ADDR_WIDTH'(`CLKRST_ADDR_RESET):    wr_reset    = 1'b1;
        default: ;
      endcase
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      for (int i = 0; i < `CLKRST_NUM_CLOCKS; i++) begin
        div_q[i] <= `CLKRST_DIV_WIDTH'(`CLKRST_DEFAULT_DIV);
      end
      valid_q <= '0;
      rst_q   <= '0;
    end else begin
      // Pulses clear themselves one cycle after the write
      valid_q <= '0;
      rst_q   <= '0;
      if (wr_division) begin
        div_q <= reg_wr_i.data.div_bytes;
      end
      // Mask bits above the channel count are dropped
      if (wr_valid) begin
        valid_q <= reg_wr_i.data.pulse_bits[`CLKRST_NUM_CLOCKS-1:0];
      end
      if (wr_reset) begin
        rst_q <= reg_wr_i.data.pulse_bits[`CLKRST_NUM_CLOCKS-1:0];
      end
    end
  end

  ////////////////////
  // Channel outputs
  ////////////////////

  always_comb begin
    for (int i = 0; i < `CLKRST_NUM_CLOCKS; i++) begin
      chan_cfg_o[i].divisor       = div_q[i];
      chan_cfg_o[i].divisor_valid = valid_q[i];
      chan_cfg_o[i].local_rst     = rst_q[i];
    end
  end

endmodule

`default_nettype wire

/* hdl/clkrst_clock_divider.sv */
`include "clkrst_macros.svh"

`default_nettype none
`timescale 1ns/1ps

module clkrst_clock_divider
  import clkrst_pkg::*;
(
  input  logic      mst_clk_i,
  input  logic      control_rst_n_d2_mst_clk,
  input  chan_cfg_t cfg_i,
  output logic      clk_o
);

  logic                         valid_d1;
  logic                         valid_d2;
  logic [`CLKRST_DIV_WIDTH-1:0] div_next;
  logic [`CLKRST_DIV_WIDTH-1:0] div_q;
  logic [`CLKRST_DIV_WIDTH-1:0] cnt_q;

  ////////////////////
  // Valid sync
  ////////////////////

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      valid_d1 <= 1'b0;
      valid_d2 <= 1'b0;
    end else begin
      valid_d1 <= cfg_i.divisor_valid;
      valid_d2 <= valid_d1;
    end
  end

  // A zero divisor runs as divide by one
  assign div_next = (cfg_i.divisor == '0) ? `CLKRST_DIV_WIDTH'(1) : cfg_i.divisor;

  ////////////////////
  // Divider
  ////////////////////

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      div_q <= `CLKRST_DIV_WIDTH'(`CLKRST_DEFAULT_DIV);
      cnt_q <= '0;
      clk_o <= 1'b0;
    end else if (valid_d2) begin
      // Restart at the new rate from a low phase
      div_q <= div_next;
      cnt_q <= '0;
      clk_o <= 1'b0;
    end else if (cnt_q == div_q - 1'b1) begin
      cnt_q <= '0;
      clk_o <= ~clk_o;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/clkrst_reset_sequencer.sv */
`include "clkrst_macros.svh"

`default_nettype none
`timescale 1ns/1ps

module clkrst_reset_sequencer (
  input  logic div_clk_i,
  input  logic mst_rst_ni,
  input  logic local_rst_i,
  output logic rst_no
);

  logic [`CLKRST_RESET_DELAY_WIDTH-1:0] cnt_q;

  // Either source asserts at once, release waits for the divided clock
  always_ff @(posedge div_clk_i or negedge mst_rst_ni or posedge local_rst_i) begin
    if (!mst_rst_ni) begin
      cnt_q  <= '0;
      rst_no <= 1'b0;
    end else if (local_rst_i) begin
      cnt_q  <= '0;
      rst_no <= 1'b0;
    end else if (cnt_q == `CLKRST_RESET_DELAY_WIDTH'(`CLKRST_RESET_DELAY - 1)) begin
      // Last edge of the delay, counter holds from here on
      rst_no <= 1'b1;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/clkrst_top.sv */
`include "clkrst_macros.svh"

`default_nettype none
`timescale 1ns/1ps

module clkrst_top
  import clkrst_pkg::*;
(
  input  logic                          mst_clk_i,
  input  logic                          control_rst_n_d2_mst_clk,
  input  logic                          mst_rst_ni,
  input  reg_write_t                    reg_wr_i,
  output logic [`CLKRST_NUM_CLOCKS-1:0] clk_o,
  output logic [`CLKRST_NUM_CLOCKS-1:0] rst_no
);

  chan_cfg_t [`CLKRST_NUM_CLOCKS-1:0] chan_cfg;
  logic                               seq_rst_n;

  // Domains also stay in reset while the control logic is reset
  assign seq_rst_n = mst_rst_ni & control_rst_n_d2_mst_clk;

  ////////////////////
  // Control
  ////////////////////

  clkrst_reg_file i_reg_file (
    .mst_clk_i                (mst_clk_i),
    .control_rst_n_d2_mst_clk (control_rst_n_d2_mst_clk),
    .reg_wr_i                 (reg_wr_i),
    .chan_cfg_o               (chan_cfg)
  );

  ////////////////////
  // Channels
  ////////////////////

  for (genvar i = 0; i < `CLKRST_NUM_CLOCKS; i++) begin : gen_chan
    clkrst_clock_divider i_divider (
      .mst_clk_i                (mst_clk_i),
      .control_rst_n_d2_mst_clk (control_rst_n_d2_mst_clk),
      .cfg_i                    (chan_cfg[i]),
      .clk_o                    (clk_o[i])
    );

    clkrst_reset_sequencer i_sequencer (
      .div_clk_i   (clk_o[i]),
      .mst_rst_ni  (seq_rst_n),
      .local_rst_i (chan_cfg[i].local_rst),
      .rst_no      (rst_no[i])
    );
  end

endmodule

`default_nettype wire

/* dv/clkrst_checker.sv */
`include "clkrst_macros.svh"

`default_nettype none
`timescale 1ns/1ps

module clkrst_checker
  import clkrst_pkg::*;
(
  input logic                               mst_clk_i,
  input logic                               control_rst_n_d2_mst_clk,
  input logic                               mst_rst_ni,
  input reg_write_t                         reg_wr_i,
  input logic      [`CLKRST_NUM_CLOCKS-1:0] clk_o,
  input logic      [`CLKRST_NUM_CLOCKS-1:0] rst_no,
  input chan_cfg_t [`CLKRST_NUM_CLOCKS-1:0] chan_cfg_i
);

  logic                          reset_write;
  logic [`CLKRST_NUM_CLOCKS-1:0] valid_pulses;

  assign reset_write = reg_wr_i.en &&
                       (reg_wr_i.addr == `CLKRST_ADDR_WIDTH'(`CLKRST_ADDR_RESET));

  always_comb begin
    for (int i = 0; i < `CLKRST_NUM_CLOCKS; i++) begin
      valid_pulses[i] = chan_cfg_i[i].divisor_valid;
    end
  end

  // Domain resets follow the master reset
  assert property (@(posedge mst_clk_i) !mst_rst_ni |-> (rst_no == '0))
    else $error("rst_no not low while mst_rst_ni is low");

  assert property (@(posedge mst_clk_i) !control_rst_n_d2_mst_clk |-> (clk_o == '0))
    else $error("clk_o not low while the control reset is active");

  // A reset-word write must not restart any divider
  assert property (@(posedge mst_clk_i) disable iff (!control_rst_n_d2_mst_clk)
    reset_write |=> (valid_pulses == '0) [*4])
    else $error("divider reload seen after a reset-word write");

endmodule

bind clkrst_top clkrst_checker checker_i (
  .mst_clk_i                (mst_clk_i),
  .control_rst_n_d2_mst_clk (control_rst_n_d2_mst_clk),
  .mst_rst_ni               (mst_rst_ni),
  .reg_wr_i                 (reg_wr_i),
  .clk_o                    (clk_o),
  .rst_no                   (rst_no),
  .chan_cfg_i               (chan_cfg)
);

`default_nettype wire

/* dv/clkrst_tb.sv */
`include "clkrst_macros.svh"

`default_nettype none
`timescale 1ns/1ps

module clkrst_tb
  import clkrst_pkg::*;
();

  localparam int NCLK    = `CLKRST_NUM_CLOCKS;
  localparam int TIMEOUT = 2000;

  logic              mst_clk_i;
  logic              control_rst_n_d2_mst_clk;
  logic              mst_rst_ni;
  reg_write_t        reg_wr_i;
  logic [NCLK-1:0]   clk_o;
  logic [NCLK-1:0]   rst_no;
  logic [16:0]       lfsr_q;
  int                error_count;

  clkrst_top clkrst_top_i (
    .mst_clk_i                (mst_clk_i),
    .control_rst_n_d2_mst_clk (control_rst_n_d2_mst_clk),
    .mst_rst_ni               (mst_rst_ni),
    .reg_wr_i                 (reg_wr_i),
    .clk_o                    (clk_o),
    .rst_no                   (rst_no)
  );

  initial begin
    mst_clk_i = 1'b0;
    forever #4 mst_clk_i = ~mst_clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic take_bits(input int count, output int value);
    value = 0;
    for (int b = 0; b < count; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | lfsr_q[0];
    end
  endtask

  task automatic idle_gap();
    int gap;
    take_bits(3, gap);
    repeat (gap) @(posedge mst_clk_i);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    @(posedge mst_clk_i);
    reg_wr_i.en              <= 1'b1;
    reg_wr_i.addr            <= addr;
    reg_wr_i.data.pulse_bits <= data;
    @(posedge mst_clk_i);
    reg_wr_i.en              <= 1'b0;
  endtask

  task automatic wait_clk_level(input int ch, input logic level);
    int t;
    t = 0;
    while (clk_o[ch] !== level) begin
      @(negedge mst_clk_i);
      t++;
      if (t > TIMEOUT) begin
        report_failure($sformatf("clk_o[%0d] never changed", ch));
      end
    end
  endtask

  // Number of samples the clock stays at one level
  task automatic count_run(input int ch, input logic level, output int len);
    len = 0;
    while (clk_o[ch] === level) begin
      len++;
      @(negedge mst_clk_i);
      if (len > TIMEOUT) begin
        report_failure($sformatf("clk_o[%0d] stopped toggling", ch));
      end
    end
  endtask

  task automatic measure_channel(input int ch, input logic [7:0] div);
    int hi;
    int lo;
    int n;
    n = (div == 8'd0) ? 1 : int'(div);
    @(negedge mst_clk_i);
    wait_clk_level(ch, 1'b0);
    wait_clk_level(ch, 1'b1);
    count_run(ch, 1'b1, hi);
    count_run(ch, 1'b0, lo);
    check_value($sformatf("clk_o[%0d] high time", ch), n, hi);
    check_value($sformatf("clk_o[%0d] low time", ch), n, lo);
  endtask

  // Called at a falling master edge with the masked resets low
  task automatic track_release(input logic [NCLK-1:0] mask);
    int              edges [NCLK];
    logic [NCLK-1:0] prev;
    logic [NCLK-1:0] done;
    int              t;
    prev = clk_o;
    done = ~mask;
    t    = 0;
    foreach (edges[i]) edges[i] = 0;
    while (done != '1) begin
      @(negedge mst_clk_i);
      t++;
      if (t > TIMEOUT) begin
        report_failure("rst_no never released");
      end
      for (int i = 0; i < NCLK; i++) begin
        if (!mask[i]) begin
          check_value($sformatf("rst_no[%0d]", i), 1, rst_no[i]);
        end else if (!done[i]) begin
          if (clk_o[i] && !prev[i]) edges[i]++;
          if (rst_no[i]) begin
            check_value($sformatf("rst_no[%0d] release edges", i),
                        `CLKRST_RESET_DELAY, edges[i]);
            done[i] = 1'b1;
          end
        end
      end
      prev = clk_o;
    end
  endtask

  // A clock that just rose cannot rise again three master edges later,
  // so the local reset pulse then ends away from a divided-clock edge
  task automatic wait_masked_rise(input logic [NCLK-1:0] mask);
    logic [NCLK-1:0] prev;
    int              t;
    t = 0;
    @(negedge mst_clk_i);
    prev = clk_o;
    @(negedge mst_clk_i);
    while (((clk_o & ~prev) & mask) != mask) begin
      prev = clk_o;
      @(negedge mst_clk_i);
      t++;
      if (t > TIMEOUT) begin
        report_failure("masked clk_o never rose together");
      end
    end
  endtask

  task automatic reset_word_check(input logic [NCLK-1:0] mask);
    logic [NCLK-1:0] others;
    int              t;
    others = ~mask;
    wait_masked_rise(mask);
    write_reg(`CLKRST_ADDR_RESET, 32'(mask));
    @(negedge mst_clk_i);
    t = 0;
    while ((rst_no & mask) != '0) begin
      @(negedge mst_clk_i);
      t++;
      if (t > TIMEOUT) begin
        report_failure("rst_no never went low after a reset-word write");
      end
    end
    check_value("rst_no unselected", others, rst_no & others);
    track_release(mask);
  endtask

  // All clocks high at a falling edge means none rises at the next rising edge
  task automatic wait_all_clk_high();
    int t;
    t = 0;
    @(negedge mst_clk_i);
    while (clk_o != '1) begin
      @(negedge mst_clk_i);
      t++;
      if (t > TIMEOUT) begin
        report_failure("clk_o never all high together");
      end
    end
  endtask

  task automatic mst_reset_check();
    wait_all_clk_high();
    @(posedge mst_clk_i);
    mst_rst_ni <= 1'b0;
    @(negedge mst_clk_i);
    check_value("rst_no", '0, rst_no);
    wait_all_clk_high();
    check_value("rst_no", '0, rst_no);
    @(posedge mst_clk_i);
    mst_rst_ni <= 1'b1;
    @(negedge mst_clk_i);
    track_release('1);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    error_count = 0;
    lfsr_q      = 17'd68391;
    reg_wr_i                 <= '0;
    control_rst_n_d2_mst_clk <= 1'b0;
    mst_rst_ni               <= 1'b0;
    repeat (4) @(posedge mst_clk_i);
    control_rst_n_d2_mst_clk <= 1'b1;
    mst_rst_ni               <= 1'b1;
    @(negedge mst_clk_i);
    track_release('1);

    fd = $fopen("dv/clkrst_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("data file dv/clkrst_testdata.txt could not be opened");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      if (line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h", op, addr, data);
      if (n != 3) continue;
      case (op)
        1: begin
          write_reg(addr[1:0], data);
          // Divider restart lands 4 cycles after the strobe
          repeat (6) begin
            @(negedge mst_clk_i);
            // Only a reset-word write may touch the domain resets
            if (addr[1:0] != `CLKRST_ADDR_WIDTH'(`CLKRST_ADDR_RESET)) begin
              check_value("rst_no", {NCLK{1'b1}}, rst_no);
            end
          end
        end
        2: begin
          for (int ch = 0; ch < NCLK; ch++) begin
            measure_channel(ch, data[8*ch +: 8]);
          end
        end
        3: reset_word_check(data[NCLK-1:0]);
        4: mst_reset_check();
        6: begin
          @(negedge mst_clk_i);
          check_value("rst_no", data, 32'(rst_no));
        end
        default: report_failure($sformatf("unknown command %0h in data file", op));
      endcase
      idle_gap();
    end
    $fclose(fd);

    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/clkrst_testdata.txt */
# Columns in hex: command address data
# 1 write, 2 half periods per clock (byte i = clk i), 3 reset-word pulse, 4 mst_rst_ni pulse, 6 rst_no level
2 0 01010101
6 0 f
1 0 04030201
1 1 0000000f
2 0 04030201
6 0 f
1 0 05000702
1 1 ffffffff
2 0 05000702
1 0 01010101
2 0 05000702
3 0 1
3 0 2
3 0 4
3 0 8
6 0 f
1 3 ffffffff
2 0 05000702
6 0 f
1 0 01010101
1 1 f
2 0 01010101
4 0 0
6 0 f
2 0 01010101
1 0 03030303
1 1 f
2 0 03030303
3 0 5
6 0 f
1 0 00000000
1 1 f
2 0 00000000
3 0 a
1 0 02020202
1 1 3
2 0 00000202
6 0 f

/* build.f */
+incdir+hdl
hdl/clkrst_pkg.sv
hdl/clkrst_reg_file.sv
hdl/clkrst_clock_divider.sv
hdl/clkrst_reset_sequencer.sv
hdl/clkrst_top.sv
dv/clkrst_checker.sv
dv/clkrst_tb.sv

/* Bender.yml */
package:
  name: clkrst

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/clkrst_pkg.sv
      - hdl/clkrst_reg_file.sv
      - hdl/clkrst_clock_divider.sv
      - hdl/clkrst_reset_sequencer.sv
      - hdl/clkrst_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/clkrst_checker.sv
      - dv/clkrst_tb.sv
